// ==== sim.f ====
verilog/lock_pkg.sv
verilog/keypad_scanner.sv
verilog/code_lock.sv
verilog/alarm_buzzer.sv
verilog/display_driver.sv
verilog/lock_top.sv
sim/lock_monitor.sv
sim/tb_lock_top.sv

// ==== sim/tb_lock_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_lock_top;
    import lock_pkg::*;

    localparam logic [15:0] SCAN_DIV  = 16'd8;
    localparam logic [15:0] TONE_HALF = 16'd4;
    localparam logic [31:0] ALARM_LEN = 32'd64;
    localparam int SCAN_CYC      = 4 * SCAN_DIV;  // one full keypad scan
    localparam int RELEASE_SCANS = 10;
    localparam int N_TESTS       = 15;
    localparam int MAX_KEYS      = 6;
    localparam int KEY_MAX_CYC   = (8 + 7 + RELEASE_SCANS) * SCAN_CYC;  // detect, hold, release
    localparam int WATCHDOG_CYC  = (N_TESTS * (MAX_KEYS * KEY_MAX_CYC + ALARM_LEN)) * 2;

    logic               clk = 1'b0;
    logic               reset;
    logic [3:0]         row;
    logic [3:0]         col;
    logic [6:0]         seg;
    logic [3:0]         an;
    logic               buzzer;
    logic               unlocked;
    logic               locked_out;
    logic [TRIES_W-1:0] tries;

    logic               key_down;
    logic [3:0]         held_pos;      // row*4 + col of the held key
    logic [15:0]        lfsr = 16'd65;
    logic               check;
    logic               report;
    logic [127:0]       cur_name;
    logic [5:0]         cur_exp;       // {unlocked, locked_out, tries, buzz}
    logic [31:0]        cur_disp;
    int                 fail_count;

    logic [127:0]       t_name  [N_TESTS];
    int                 t_nkeys [N_TESTS];
    logic [23:0]        t_keys  [N_TESTS];  // first key in the top nibble
    logic [5:0]         t_exp   [N_TESTS];
    logic [31:0]        t_disp  [N_TESTS];
    int                 n_tests = 0;

    always #5 clk = ~clk;

    // pressed switch pulls its row low while its column is driven
    always_comb begin
        row = 4'hF;
        if (key_down && !col[held_pos[1:0]]) row[held_pos[3:2]] = 1'b0;
    end

    lock_top #(.SCAN_DIV(SCAN_DIV), .TONE_HALF(TONE_HALF), .ALARM_LEN(ALARM_LEN)) dut (
        .clk(clk), .reset(reset), .row(row), .col(col), .seg(seg), .an(an),
        .buzzer(buzzer), .unlocked(unlocked), .locked_out(locked_out), .tries(tries)
    );

    lock_monitor u_monitor (
        .clk(clk), .reset(reset), .check(check), .report(report), .name(cur_name),
        .exp_unlocked(cur_exp[5]), .exp_locked_out(cur_exp[4]), .exp_tries(cur_exp[3:1]),
        .exp_buzz(cur_exp[0]), .exp_disp(cur_disp), .buzzer(buzzer), .unlocked(unlocked),
        .locked_out(locked_out), .tries(tries), .seg(seg), .an(an), .fails(fail_count)
    );

    // board layout 1 2 3 A / 4 5 6 B / 7 8 9 C / * 0 # D
    function automatic logic [3:0] key_pos(input logic [3:0] code);
        case (code)
            4'd0:       key_pos = 4'd13;
            KEY_ENTER:  key_pos = 4'd14;  // '#'
            KEY_CANCEL: key_pos = 4'd12;  // '*'
            KEY_ADMIN:  key_pos = 4'd3;   // 'A'
            default:    key_pos = 4'((int'(code) - 1) / 3 * 4 + (int'(code) - 1) % 3);
        endcase
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | lfsr[0];
        end
    endtask

    task automatic press_key(input logic [3:0] code);
        int extra;
        take_bits(3, extra);
        @(negedge clk);
        held_pos = key_pos(code);
        key_down = 1'b1;
        wait (dut.key_ack === 1'b1);  // lock has taken the key
        @(negedge clk);
        repeat (extra * SCAN_CYC) @(negedge clk);
        key_down = 1'b0;
        repeat (RELEASE_SCANS * SCAN_CYC) @(negedge clk);
    endtask

    task automatic add_test(input logic [127:0] name, input int nk, input logic [23:0] keys,
                            input logic ul, input logic lo, input logic [2:0] tr,
                            input logic bz, input logic [31:0] disp);
        t_name[n_tests]  = name;
        t_nkeys[n_tests] = nk;
        t_keys[n_tests]  = keys;
        t_exp[n_tests]   = {ul, lo, tr, bz};
        t_disp[n_tests]  = disp;
        n_tests++;
    endtask

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYC);
        $display("Test failed");
        $finish;
    end

    initial begin
        reset    = 1'b1;
        key_down = 1'b0;
        held_pos = 4'd0;
        check    = 1'b0;
        report   = 1'b0;
        cur_name = '0;
        cur_exp  = '0;
        cur_disp = "    ";
        // keys in hex: A enter, B cancel, C admin; then unlocked, locked out, tries, buzz
        add_test("open_ok",       4, 24'h246A00, 1, 0, 0, 0, "PASS");
        add_test("cancel_lock",   1, 24'hB00000, 0, 0, 0, 0, "-   ");
        add_test("wrong_code",    4, 24'h123A00, 0, 0, 1, 1, "-   ");
        add_test("short_entry",   3, 24'h24A000, 0, 0, 1, 0, "- 24");
        add_test("cancel_reopen", 5, 24'hB246A0, 1, 0, 1, 0, "PASS");
        add_test("repeat_digits", 4, 24'hB22400, 0, 0, 1, 0, "-224");
        add_test("cancel_clear",  5, 24'hB246A0, 1, 0, 1, 0, "PASS");
        add_test("fail_2",        5, 24'hB999A0, 0, 0, 2, 1, "-   ");
        add_test("fail_3",        4, 24'h111A00, 0, 0, 3, 1, "-   ");
        add_test("fail_4",        4, 24'h000A00, 0, 0, 4, 1, "-   ");
        add_test("fail_5",        4, 24'h875A00, 0, 0, 5, 1, "-   ");
        add_test("lockout",       4, 24'h245A00, 0, 1, 6, 1, "LOC ");
        add_test("locked_good",   4, 24'h246A00, 0, 1, 6, 0, "LOC ");
        add_test("admin_clear",   1, 24'hC00000, 0, 0, 0, 0, "-   ");
        add_test("open_after",    4, 24'h246A00, 1, 0, 0, 0, "PASS");
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < n_tests; i++) begin
            for (int j = 0; j < t_nkeys[i]; j++) begin
                press_key(t_keys[i][23 - 4*j -: 4]);
            end
            repeat (ALARM_LEN) @(negedge clk);  // let any alarm run out
            cur_name = t_name[i];
            cur_exp  = t_exp[i];
            cur_disp = t_disp[i];
            check    = 1'b1;
            @(negedge clk);
            check = 1'b0;
        end
        report = 1'b1;
        @(negedge clk);
        report = 1'b0;
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/lock_monitor.sv ====
`timescale 1ns/100ps
`default_nettype none

module lock_monitor (
    input  logic         clk,
    input  logic         reset,
    input  logic         check,
    input  logic         report,
    input  logic [127:0] name,
    input  logic         exp_unlocked,
    input  logic         exp_locked_out,
    input  logic [2:0]   exp_tries,
    input  logic         exp_buzz,
    input  logic [31:0]  exp_disp,        // four characters, leftmost place first
    input  logic         buzzer,
    input  logic         unlocked,
    input  logic         locked_out,
    input  logic [2:0]   tries,
    input  logic [6:0]   seg,
    input  logic [3:0]   an,
    output int           fails
);
    // {g,f,e,d,c,b,a}, active low
    localparam logic [0:9][6:0] DIGIT_SEG = {
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10
    };

    logic [6:0] shown [0:3];  // last pattern seen on each place
    logic       buzz_prev;
    int         buzz_edges;   // buzzer changes since the last check
    int         passes;

    function automatic logic [6:0] char_seg(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            char_seg = DIGIT_SEG[c - "0"];
        end else begin
            case (c)
                "-":     char_seg = 7'h3F;
                "P":     char_seg = 7'h0C;
                "A":     char_seg = 7'h08;
                "S":     char_seg = 7'h12;
                "L":     char_seg = 7'h47;
                "O":     char_seg = 7'h40;
                "C":     char_seg = 7'h46;
                default: char_seg = 7'h7F;  // blank
            endcase
        end
    endfunction

    task automatic compare(input string what, input logic [7:0] exp, input logic [7:0] act,
                           inout int errs);
        if (exp !== act) begin
            $display("MISMATCH %0s %0s expected %0h actual %0h", name, what, exp, act);
            errs++;
        end
    endtask

    task automatic check_test();
        int errs;
        errs = 0;
        compare("unlocked", exp_unlocked, unlocked, errs);
        compare("locked_out", exp_locked_out, locked_out, errs);
        compare("tries", exp_tries, tries, errs);
        for (int p = 0; p < 4; p++) begin
            compare($sformatf("seg place %0d", p), char_seg(exp_disp[8*p +: 8]), shown[p], errs);
        end
        if (exp_buzz && buzz_edges < 2) begin
            $display("test %0s: alarm expected but the buzzer never toggled", name);
            errs++;
        end else if (!exp_buzz && buzz_edges != 0) begin
            $display("test %0s: buzzer sounded without a failed attempt", name);
            errs++;
        end
        buzz_edges = 0;
        if (errs == 0) begin
            passes++;
            $display("test %0s: ok", name);
        end else begin
            fails++;
            $display("test %0s: %0d error(s)", name, errs);
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            buzz_prev  = 1'b0;
            buzz_edges = 0;
            passes     = 0;
            fails      = 0;
        end else begin
            if (buzzer != buzz_prev) buzz_edges++;
            buzz_prev = buzzer;
            for (int p = 0; p < 4; p++) begin
                if (!an[p]) shown[p] = seg;  // active anode
            end
            if (check) check_test();
            if (report) begin
                $display("tests run %0d, passed %0d, failed %0d", passes + fails, passes, fails);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lock_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lock_top #(
    parameter logic [15:0] SCAN_DIV  = lock_pkg::SCAN_DIV_DEFAULT,
    parameter logic [15:0] TONE_HALF = lock_pkg::TONE_HALF_DEFAULT,
    parameter logic [31:0] ALARM_LEN = lock_pkg::ALARM_LEN_DEFAULT
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [3:0]                   row,
    output logic [3:0]                   col,
    output logic [6:0]                   seg,
    output logic [3:0]                   an,
    output logic                         buzzer,
    output logic                         unlocked,
    output logic                         locked_out,
    output logic [lock_pkg::TRIES_W-1:0] tries
);
    import lock_pkg::*;

    logic             key_req;
    logic             key_ack;
    logic [KEY_W-1:0] key_code;
    logic [11:0]      digits;
    logic [1:0]       digit_count;
    logic             alarm_start;

    keypad_scanner #(.SCAN_DIV(SCAN_DIV)) u_scanner (
        .clk(clk), .reset(reset), .row(row), .col(col),
        .key_req(key_req), .key_code(key_code), .key_ack(key_ack)
    );

    code_lock u_lock (
        .clk(clk), .reset(reset), .key_req(key_req), .key_code(key_code),
        .key_ack(key_ack), .digits(digits), .digit_count(digit_count),
        .unlocked(unlocked), .locked_out(locked_out), .tries(tries),
        .alarm_start(alarm_start)
    );

    alarm_buzzer #(.TONE_HALF(TONE_HALF), .ALARM_LEN(ALARM_LEN)) u_buzzer (
        .clk(clk), .reset(reset), .alarm_start(alarm_start), .buzzer(buzzer)
    );

    display_driver #(.SCAN_DIV(SCAN_DIV)) u_display (
        .clk(clk), .reset(reset), .digits(digits), .digit_count(digit_count),
        .unlocked(unlocked), .locked_out(locked_out), .seg(seg), .an(an)
    );

endmodule

`default_nettype wire

// ==== verilog/display_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

module display_driver #(
    parameter logic [15:0] SCAN_DIV = lock_pkg::SCAN_DIV_DEFAULT
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [11:0] digits,
    input  logic [1:0]  digit_count,
    input  logic        unlocked,
    input  logic        locked_out,
    output logic [6:0]  seg,
    output logic [3:0]  an
);
    import lock_pkg::*;

    logic [15:0]      div_cnt;
    logic [1:0]       sel;        // place being driven, 3 is leftmost
    logic [SYM_W-1:0] sym [0:3];

    always_comb begin
        if (locked_out) begin
            sym[3] = SYM_L;
            sym[2] = SYM_O;
            sym[1] = SYM_C;
            sym[0] = SYM_BLANK;
        end else if (unlocked) begin
            sym[3] = SYM_P;
            sym[2] = SYM_A;
            sym[1] = SYM_S;
            sym[0] = SYM_S;
        end else begin
            // entry shown right-aligned after a dash
            sym[3] = SYM_DASH;
            sym[2] = (digit_count >= 2'd3) ? {1'b0, digits[11:8]} : SYM_BLANK;
            sym[1] = (digit_count >= 2'd2) ? {1'b0, digits[7:4]}  : SYM_BLANK;
            sym[0] = (digit_count >= 2'd1) ? {1'b0, digits[3:0]}  : SYM_BLANK;
        end
    end

    assign an  = ~(4'b0001 << sel);
    assign seg = SEG_TABLE[sym[sel]];

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= 16'd0;
            sel     <= 2'd0;
        end else if (div_cnt == SCAN_DIV - 16'd1) begin
            div_cnt <= 16'd0;
            sel     <= sel + 2'd1;  // next anode
        end else begin
            div_cnt <= div_cnt + 16'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alarm_buzzer.sv ====
`timescale 1ns/100ps
`default_nettype none

module alarm_buzzer #(
    parameter logic [15:0] TONE_HALF = lock_pkg::TONE_HALF_DEFAULT,
    parameter logic [31:0] ALARM_LEN = lock_pkg::ALARM_LEN_DEFAULT
) (
    input  logic clk,
    input  logic reset,
    input  logic alarm_start,
    output logic buzzer
);
    logic        active;
    logic [31:0] dur_cnt;   // cycles since the last trigger
    logic [15:0] tone_cnt;  // half-period divider

    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            dur_cnt  <= 32'd0;
            tone_cnt <= 16'd0;
            buzzer   <= 1'b0;
        end else if (alarm_start) begin
            // a new trigger restarts the duration
            active   <= 1'b1;
            dur_cnt  <= 32'd0;
            tone_cnt <= 16'd0;
            buzzer   <= 1'b1;
        end else if (active) begin
            if (dur_cnt == ALARM_LEN - 32'd1) begin
                active <= 1'b0;
                buzzer <= 1'b0;  // silent when done
            end else begin
                dur_cnt <= dur_cnt + 32'd1;
                if (tone_cnt == TONE_HALF - 16'd1) begin
                    tone_cnt <= 16'd0;
                    buzzer   <= ~buzzer;
                end else begin
                    tone_cnt <= tone_cnt + 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/code_lock.sv ====
`timescale 1ns/100ps
`default_nettype none

module code_lock (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         key_req,
    input  logic [lock_pkg::KEY_W-1:0]   key_code,
    output logic                         key_ack,
    output logic [11:0]                  digits,
    output logic [1:0]                   digit_count,
    output logic                         unlocked,
    output logic                         locked_out,
    output logic [lock_pkg::TRIES_W-1:0] tries,
    output logic                         alarm_start
);
    import lock_pkg::*;

    logic               key_fire;
    logic               is_digit;
    logic               entry_full;
    logic               code_match;
    logic [TRIES_W-1:0] tries_inc;

    // new request seen, ack rises at this edge
    assign key_fire   = key_req && !key_ack;
    assign is_digit   = (key_code <= KEY_W'(9));
    assign entry_full = (digit_count == 2'(CODE_DIGITS));
    assign code_match = (digits == SECRET_CODE);
    assign tries_inc  = tries + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            key_ack     <= 1'b0;
            digits      <= 12'd0;
            digit_count <= 2'd0;
            unlocked    <= 1'b0;
            locked_out  <= 1'b0;
            tries       <= '0;
            alarm_start <= 1'b0;
        end else begin
            alarm_start <= 1'b0;  // single-cycle pulse

            // four-phase handshake
            if (key_fire) begin
                key_ack <= 1'b1;
            end else if (!key_req) begin
                key_ack <= 1'b0;
            end

            if (key_fire) begin
                if (key_code == KEY_ADMIN) begin
                    // admin clears everything
                    digits      <= 12'd0;
                    digit_count <= 2'd0;
                    unlocked    <= 1'b0;
                    locked_out  <= 1'b0;
                    tries       <= '0;
                end else if (!locked_out) begin
                    if (is_digit) begin
                        if (!entry_full) begin
                            digits      <= {digits[7:0], key_code};  // newest on the right
                            digit_count <= digit_count + 2'd1;
                        end
                    end else if (key_code == KEY_ENTER) begin
                        if (entry_full) begin
                            if (code_match) begin
                                unlocked <= 1'b1;
                            end else begin
                                digits      <= 12'd0;
                                digit_count <= 2'd0;
                                tries       <= tries_inc;
                                alarm_start <= 1'b1;
                                if (tries_inc == TRIES_W'(MAX_TRIES)) begin
                                    locked_out <= 1'b1;
                                end
                            end
                        end
                    end else if (key_code == KEY_CANCEL) begin
                        digits      <= 12'd0;
                        digit_count <= 2'd0;
                        unlocked    <= 1'b0;
                    end
                    // codes 13..15 do nothing
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/keypad_scanner.sv ====
`timescale 1ns/100ps
`default_nettype none

module keypad_scanner #(
    parameter logic [15:0] SCAN_DIV = lock_pkg::SCAN_DIV_DEFAULT
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [3:0]                 row,
    output logic [3:0]                 col,
    output logic                       key_req,
    output logic [lock_pkg::KEY_W-1:0] key_code,
    input  logic                       key_ack
);
    import lock_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_SCANS + 1);
    localparam logic [CNT_W-1:0] STABLE_MAX = CNT_W'(DEBOUNCE_SCANS);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_RELEASE, S_QUIET} state_t;

    state_t           state;
    logic [15:0]      div_cnt;
    logic [1:0]       col_idx;
    logic [3:0]       row_meta;
    logic [3:0]       row_s;
    logic [15:0]      scan_acc;    // pressed map built column by column
    logic [15:0]      frame;
    logic [15:0]      last_frame;
    logic [CNT_W-1:0] stable_cnt;
    logic [CNT_W-1:0] stable_next;
    logic [3:0]       key_idx;
    logic             step;
    logic             scan_done;
    logic             frame_single;
    logic             frame_stable;

    assign col       = ~(4'b0001 << col_idx);  // one column low
    assign step      = (div_cnt == SCAN_DIV - 16'd1) && (state != S_REQ);
    assign scan_done = step && (col_idx == 2'd3);

    // merge the current column's rows into the map
    always_comb begin
        frame = scan_acc;
        for (int r = 0; r < 4; r++) begin
            frame[r*4 + col_idx] = ~row_s[r];
        end
    end

    assign frame_single = (frame != 16'd0) && ((frame & (frame - 16'd1)) == 16'd0);
    assign stable_next  = (frame != last_frame) ? CNT_W'(1) :
                          (stable_cnt == STABLE_MAX) ? stable_cnt : stable_cnt + 1'b1;
    assign frame_stable = (stable_next == STABLE_MAX);

    always_comb begin
        key_idx = 4'd0;
        for (int i = 0; i < 16; i++) begin
            if (frame[i]) key_idx = 4'(i);  // one-hot, only one hit
        end
    end

    always_ff @(posedge clk) begin
        row_meta <= row;  // rows are asynchronous to clk
        row_s    <= row_meta;
        if (state == S_IDLE && scan_done && frame_stable && frame_single) begin
            key_code <= KEY_MAP[key_idx];
        end
        if (reset) begin
            state      <= S_IDLE;
            div_cnt    <= 16'd0;
            col_idx    <= 2'd0;
            scan_acc   <= 16'd0;
            last_frame <= 16'd0;
            stable_cnt <= '0;
            key_req    <= 1'b0;
        end else begin
            if (state != S_REQ) begin  // scanning pauses while an event is pending
                div_cnt <= (div_cnt == SCAN_DIV - 16'd1) ? 16'd0 : div_cnt + 16'd1;
            end
            if (step) begin
                col_idx  <= col_idx + 2'd1;
                scan_acc <= frame;
            end
            if (scan_done) begin
                last_frame <= frame;
                stable_cnt <= stable_next;
            end
            case (state)
                S_IDLE: begin
                    if (scan_done && frame_stable && frame_single) begin
                        key_req <= 1'b1;
                        state   <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (key_ack) begin
                        key_req <= 1'b0;
                        state   <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (scan_done && frame == 16'd0) state <= S_QUIET;
                end
                default: begin  // S_QUIET, wait for a clean release
                    if (scan_done) begin
                        if (frame != 16'd0) state <= S_RELEASE;
                        else if (frame_stable && !key_ack) state <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lock_pkg.sv ====
`default_nettype none

package lock_pkg;

    // key codes, 0..9 are the digits
    localparam int KEY_W = 4;
    localparam logic [KEY_W-1:0] KEY_ENTER  = 4'd10;
    localparam logic [KEY_W-1:0] KEY_CANCEL = 4'd11;
    localparam logic [KEY_W-1:0] KEY_ADMIN  = 4'd12;

    // index is row*4 + col; layout 1 2 3 A / 4 5 6 B / 7 8 9 C / * 0 # D
    localparam logic [15:0][KEY_W-1:0] KEY_MAP = {
        4'd15, KEY_ENTER, 4'd0, KEY_CANCEL,  // row 3: D # 0 *
        4'd14, 4'd9,      4'd8, 4'd7,        // row 2: C 9 8 7
        4'd13, 4'd6,      4'd5, 4'd4,        // row 1: B 6 5 4
        KEY_ADMIN, 4'd3,  4'd2, 4'd1         // row 0: A 3 2 1
    };

    localparam int CODE_DIGITS = 3;
    localparam logic [11:0] SECRET_CODE = {4'd2, 4'd4, 4'd6};  // BCD
    localparam int MAX_TRIES = 6;
    localparam int TRIES_W = 3;

    // defaults for a 50 MHz board clock
    localparam logic [15:0] SCAN_DIV_DEFAULT  = 16'd50000;  // 1 ms per column
    localparam int          DEBOUNCE_SCANS    = 4;
    localparam logic [15:0] TONE_HALF_DEFAULT = 16'd50000;  // 500 Hz tone
    localparam logic [31:0] ALARM_LEN_DEFAULT = 32'd150000000;

    // display symbols, digits 0..9 map to themselves
    localparam int SYM_W = 5;
    localparam logic [SYM_W-1:0] SYM_BLANK = 5'd10;
    localparam logic [SYM_W-1:0] SYM_DASH  = 5'd11;
    localparam logic [SYM_W-1:0] SYM_P     = 5'd12;
    localparam logic [SYM_W-1:0] SYM_A     = 5'd13;
    localparam logic [SYM_W-1:0] SYM_S     = 5'd14;
    localparam logic [SYM_W-1:0] SYM_L     = 5'd15;
    localparam logic [SYM_W-1:0] SYM_O     = 5'd16;
    localparam logic [SYM_W-1:0] SYM_C     = 5'd17;

    // seg[6:0] = {g,f,e,d,c,b,a}, active low
    localparam logic [6:0] SEG_TABLE [0:31] = '{
        0: 7'h40, 1: 7'h79, 2: 7'h24, 3: 7'h30, 4: 7'h19,
        5: 7'h12, 6: 7'h02, 7: 7'h78, 8: 7'h00, 9: 7'h10,
        10: 7'h7F,  // blank
        11: 7'h3F,  // dash
        12: 7'h0C,  // P
        13: 7'h08,  // A
        14: 7'h12,  // S
        15: 7'h47,  // L
        16: 7'h40,  // O
        17: 7'h46,  // C
        default: 7'h7F
    };

endpackage

`default_nettype wire
